// ==== common/init_table.svh ====
/*
 * init table for two clock mux chips, multi-device layout
 * data block first, then address block, then a single stop
 * included inside init_rom after the package import
 */

`ifndef INIT_TABLE_SVH
`define INIT_TABLE_SVH

localparam table_entry_t INIT_TABLE [INIT_TABLE_LEN] = '{
    OP_DATA_BLOCK,    // 0: data block starts at 1
    OP_START_CURRENT,
    {1'b1, 8'd2},     // pll bandwidth
    {1'b1, 8'hA0},
    OP_START_CURRENT,
    {1'b1, 8'd3},     // outputs off during ical
    {1'b1, 8'h10},
    OP_START_CURRENT,
    {1'b1, 8'd5},     // clkout1/2 format
    {1'b1, 8'hED},
    OP_START_CURRENT,
    {1'b1, 8'd6},     // clkout3/4 format
    {1'b1, 8'h3D},
    OP_START_CURRENT,
    {1'b1, 8'd7},     // clkout5 format
    {1'b1, 8'h3A},
    OP_START_CURRENT,
    {1'b1, 8'd20},    // lol pin enable
    {1'b1, 8'h3E},
    OP_START_CURRENT,
    {1'b1, 8'd25},    // n1_hs
    {1'b1, 8'h40},
    OP_START_CURRENT,
    {1'b1, 8'd27},    // nc1_ls
    {1'b1, 8'h05},
    OP_START_CURRENT,
    {1'b1, 8'd30},    // nc2_ls
    {1'b1, 8'h05},
    OP_START_CURRENT,
    {1'b1, 8'd33},    // nc3_ls
    {1'b1, 8'h05},
    OP_START_CURRENT,
    {1'b1, 8'd36},    // nc4_ls
    {1'b1, 8'h05},
    OP_START_CURRENT,
    {1'b1, 8'd39},    // nc5_ls
    {1'b1, 8'h05},
    OP_START_CURRENT,
    {1'b1, 8'd40},    // n2_hs
    {1'b1, 8'hA0},
    OP_START_CURRENT,
    {1'b1, 8'd41},    // n2_ls upper
    {1'b1, 8'h01},
    OP_START_CURRENT,
    {1'b1, 8'd42},    // n2_ls lower
    {1'b1, 8'h3B},
    OP_START_CURRENT,
    {1'b1, 8'd45},    // n31
    {1'b1, 8'h4E},
    OP_START_CURRENT,
    {1'b1, 8'd48},    // n32
    {1'b1, 8'h4E},
    OP_START_CURRENT,
    {1'b1, 8'd51},    // n33
    {1'b1, 8'h4E},
    OP_START_CURRENT,
    {1'b1, 8'd54},    // n34
    {1'b1, 8'h4E},
    OP_START_CURRENT,
    {1'b1, 8'd141},   // no output skew
    {1'b1, 8'h00},
    OP_START_CURRENT,
    {1'b1, 8'd136},   // soft reset, last write per device
    {1'b1, 8'h40},
    OP_ADDR_BLOCK,    // 64: address block starts at 65
    {2'b01, 7'h69},   // first mux
    {2'b01, 7'h68},   // second mux
    OP_STOP           // 67: end of run
};

`endif

// ==== common/i2c_init_pkg.sv ====
/*
 * shared widths, entry encodings and enums for the I2C init sequencer
 * table entries are 9 bits; only the multi-device encodings are decoded
 * anything not listed below is treated as stop by the sequencer
 */

package i2c_init_pkg;

    // command table size
    localparam int INIT_TABLE_LEN = 68;
    localparam int TABLE_AW       = $clog2(INIT_TABLE_LEN);  // 7 bits for 68 entries

    typedef logic [TABLE_AW-1:0] table_addr_t;  // table index
    typedef logic [8:0]          table_entry_t; // one command word
    typedef logic [6:0]          i2c_addr_t;    // 7-bit device address
    typedef logic [7:0]          i2c_byte_t;    // data byte

    // named entry codes, top two bits zero
    localparam table_entry_t OP_STOP          = 9'd0;
    localparam table_entry_t OP_START_CURRENT = 9'd3; // start write to current device
    localparam table_entry_t OP_ADDR_BLOCK    = 9'd8; // address block marker
    localparam table_entry_t OP_DATA_BLOCK    = 9'd9; // data block marker

    // sequencer FSM
    typedef enum logic [1:0] {
        ST_IDLE            = 2'd0, // waiting for start edge
        ST_FIND_ADDR_BLOCK = 2'd1, // scanning for address block
        ST_NEXT_ADDR       = 2'd2, // reading next device address
        ST_REPLAY          = 2'd3  // running the data block
    } seq_state_t;

    // request from sequencer to output stage
    typedef enum logic [1:0] {
        OP_NONE       = 2'd0,
        OP_SET_START  = 2'd1, // latch address, arm start flag, no beat
        OP_WRITE_BYTE = 2'd2, // command + data beat
        OP_SEND_STOP  = 2'd3  // command beat only
    } seq_op_t;

    // 1 dddddddd : write data byte
    function automatic logic entry_is_data(table_entry_t e);
        return e[8];
    endfunction

    // 01 aaaaaaa : device address, address block only
    function automatic logic entry_is_addr(table_entry_t e);
        return e[8:7] == 2'b01;
    endfunction

    // low byte of a data entry
    function automatic i2c_byte_t entry_byte(table_entry_t e);
        return e[7:0];
    endfunction

    // low 7 bits of an address entry
    function automatic i2c_addr_t entry_addr(table_entry_t e);
        return e[6:0];
    endfunction

endpackage

// ==== common/seq_cmd_if.sv ====
/*
 * request channel from the sequencer to the master output stage
 * issue is a single-cycle strobe, only raised while pending is low
 * pending covers both output valids, so a request is never overwritten
 */

`timescale 1ns/1ps

interface seq_cmd_if import i2c_init_pkg::*; ();

    seq_op_t   op;      // request kind, meaningful with issue
    i2c_addr_t addr;    // device address for OP_SET_START
    i2c_byte_t data;    // byte for OP_WRITE_BYTE
    logic      issue;   // one cycle per request
    logic      pending; // output stage still holding a beat

    // sequencer side
    modport seq (
        output op,
        output addr,
        output data,
        output issue,
        input  pending
    );

    // output stage side
    modport out (
        input  op,
        input  addr,
        input  data,
        input  issue,
        output pending
    );

endinterface

// ==== sequencer/init_rom.sv ====
/*
 * command table ROM, one-cycle registered read, no reset on the data
 * contents come from init_table.svh at elaboration
 * reads past the end of the table return a stop entry
 */

`timescale 1ns/1ps

module init_rom import i2c_init_pkg::*; (
    input  logic         clk,
    input  table_addr_t  rd_addr,
    output table_entry_t entry
);

    `include "init_table.svh"

    table_entry_t mem [INIT_TABLE_LEN];

    initial begin
        for (int i = 0; i < INIT_TABLE_LEN; i++)
            mem[i] = INIT_TABLE[i];
    end

    // address is 7 bits wide, table is shorter
    always_ff @(posedge clk) begin
        if (rd_addr < INIT_TABLE_LEN)
            entry <= mem[rd_addr];
        else
            entry <= OP_STOP; // off the end ends the run
    end

endmodule

// ==== sequencer/i2c_init_sequencer.sv ====
/*
 * walks the init table in multi-device mode and issues requests
 * one entry per cycle while the output stage is empty
 * a run needs start low for a cycle and then high while idle
 * stop or any undefined entry sends one stop beat and returns to idle
 */

`timescale 1ns/1ps

module i2c_init_sequencer import i2c_init_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    output logic         busy,
    output table_addr_t  rd_addr,
    input  table_entry_t entry,
    seq_cmd_if.seq       cmd
);

    seq_state_t  state_q, state_d;
    table_addr_t addr_q, addr_d;         // index of the entry now on the rom port
    table_addr_t data_ptr_q, data_ptr_d; // first entry after data block marker
    table_addr_t addr_ptr_q, addr_ptr_d; // next address to serve
    i2c_addr_t   dev_addr_q, dev_addr_d; // current device
    logic        start_seen_q, start_seen_d;
    table_addr_t addr_inc;
    logic        do_stop;

    assign addr_inc = addr_q + 1'b1;

    // entry matches addr_q a cycle later since the rom registers the address
    assign rd_addr = addr_d;

    always_comb begin
        state_d      = state_q;
        addr_d       = addr_q;  // held so the rom rereads the same entry
        data_ptr_d   = data_ptr_q;
        addr_ptr_d   = addr_ptr_q;
        dev_addr_d   = dev_addr_q;
        start_seen_d = start_seen_q;
        do_stop      = 1'b0;

        cmd.issue = 1'b0;
        cmd.op    = OP_NONE;
        cmd.addr  = dev_addr_q;
        cmd.data  = entry_byte(entry);

        if (!cmd.pending) begin  // wait for both output beats to drain
            case (state_q)
                ST_IDLE: begin
                    if (start && !start_seen_q) begin
                        start_seen_d = 1'b1;
                        addr_d       = '0;
                        state_d      = ST_FIND_ADDR_BLOCK;
                    end
                end
                ST_FIND_ADDR_BLOCK: begin
                    if (entry == OP_DATA_BLOCK) begin
                        data_ptr_d = addr_inc; // remember replay point
                        addr_d     = addr_inc;
                    end else if (entry == OP_ADDR_BLOCK) begin
                        addr_ptr_d = addr_inc;
                        addr_d     = addr_inc;
                        state_d    = ST_NEXT_ADDR;
                    end else if (entry_is_data(entry) || entry_is_addr(entry) ||
                                 entry == OP_START_CURRENT) begin
                        addr_d = addr_inc; // data block body is skipped for now
                    end else begin
                        do_stop = 1'b1;
                    end
                end
                ST_NEXT_ADDR: begin
                    if (entry_is_addr(entry)) begin
                        dev_addr_d = entry_addr(entry);
                        addr_ptr_d = addr_inc;
                        addr_d     = data_ptr_q; // back to top of data block
                        state_d    = ST_REPLAY;
                    end else begin
                        do_stop = 1'b1; // address list exhausted
                    end
                end
                ST_REPLAY: begin
                    if (entry_is_data(entry)) begin
                        cmd.issue = 1'b1;
                        cmd.op    = OP_WRITE_BYTE;
                        addr_d    = addr_inc;
                    end else if (entry == OP_START_CURRENT) begin
                        cmd.issue = 1'b1;
                        cmd.op    = OP_SET_START; // substitutes dev_addr_q
                        addr_d    = addr_inc;
                    end else if (entry == OP_ADDR_BLOCK) begin
                        addr_d  = addr_ptr_q; // data block done so serve the next device
                        state_d = ST_NEXT_ADDR;
                    end else begin
                        do_stop = 1'b1;
                    end
                end
                default: begin
                    state_d = ST_IDLE;
                end
            endcase
        end

        if (do_stop) begin
            cmd.issue = 1'b1;
            cmd.op    = OP_SEND_STOP;
            state_d   = ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= ST_IDLE;
            addr_q       <= '0;
            data_ptr_q   <= '0;
            addr_ptr_q   <= '0;
            dev_addr_q   <= '0;
            start_seen_q <= 1'b0;
            busy         <= 1'b0;
        end else begin
            state_q      <= state_d;
            addr_q       <= addr_d;
            data_ptr_q   <= data_ptr_d;
            addr_ptr_q   <= addr_ptr_d;
            dev_addr_q   <= dev_addr_d;
            start_seen_q <= start & start_seen_d; // rearms once start drops
            busy         <= (state_q != ST_IDLE); // lags the fsm by one cycle
        end
    end

endmodule

// ==== source/i2c_master_out.sv ====
/*
 * output registers toward the I2C master command and data channels
 * each valid clears on its own ready; payload holds until accepted
 * requests arrive only while pending is low, so none is lost
 * cmd_start is set on the first write after OP_SET_START only
 */

`timescale 1ns/1ps

module i2c_master_out import i2c_init_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    seq_cmd_if.out    req,
    output i2c_addr_t cmd_address,
    output logic      cmd_start,
    output logic      cmd_write,
    output logic      cmd_stop,
    output logic      cmd_valid,
    input  logic      cmd_ready,
    output i2c_byte_t data_out,
    output logic      data_out_valid,
    input  logic      data_out_ready
);

    logic start_pend; // sticky start, consumed by the next write

    assign req.pending = cmd_valid | data_out_valid;

    // valids and start flag
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_valid      <= 1'b0;
            data_out_valid <= 1'b0;
            start_pend     <= 1'b0;
        end else begin
            if (cmd_ready)
                cmd_valid <= 1'b0;      // channels drain independently
            if (data_out_ready)
                data_out_valid <= 1'b0;
            if (req.issue) begin
                case (req.op)
                    OP_SET_START: start_pend <= 1'b1;
                    OP_WRITE_BYTE: begin
                        cmd_valid      <= 1'b1;
                        data_out_valid <= 1'b1;
                        start_pend     <= 1'b0;
                    end
                    OP_SEND_STOP: cmd_valid <= 1'b1; // no data beat with stop
                    default: ;
                endcase
            end
        end
    end

    // beat payload, loaded only with a request
    always_ff @(posedge clk) begin
        if (req.issue) begin
            case (req.op)
                OP_SET_START: cmd_address <= req.addr;
                OP_WRITE_BYTE: begin
                    cmd_start <= start_pend;
                    cmd_write <= 1'b1;
                    cmd_stop  <= 1'b0;
                    data_out  <= req.data;
                end
                OP_SEND_STOP: begin
                    cmd_start <= 1'b0;
                    cmd_write <= 1'b0;
                    cmd_stop  <= 1'b1; // address left as last device
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== source/i2c_init_top.sv ====
/*
 * boot-time I2C init for two clock mux chips
 * cmd_read, cmd_write_multiple and data_out_last are tied at the master
 * end of run is the accepted stop beat; busy is registered
 */

`timescale 1ns/1ps

module i2c_init_top import i2c_init_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    output i2c_addr_t cmd_address,
    output logic      cmd_start,
    output logic      cmd_write,
    output logic      cmd_stop,
    output logic      cmd_valid,
    input  logic      cmd_ready,
    output i2c_byte_t data_out,
    output logic      data_out_valid,
    input  logic      data_out_ready,
    output logic      busy
);

    table_addr_t  rd_addr;
    table_entry_t entry;

    seq_cmd_if seq_cmd ();  // sequencer to output stage

    init_rom u_rom (
        .clk     (clk),
        .rd_addr (rd_addr),
        .entry   (entry)
    );

    i2c_init_sequencer u_seq (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .busy    (busy),
        .rd_addr (rd_addr),
        .entry   (entry),
        .cmd     (seq_cmd.seq)
    );

    i2c_master_out u_out (
        .clk            (clk),
        .rst            (rst),
        .req            (seq_cmd.out),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

endmodule

// ==== bench/i2c_init_checker.sv ====
/*
 * handshake checks on the master side of i2c_init_top, attached by bind
 * a waiting beat must keep valid and payload until its ready
 * fail_count holds the number of failed assertions
 */

`timescale 1ns/1ps

module i2c_init_checker import i2c_init_pkg::*; (
    input logic      clk,
    input logic      rst,
    input i2c_addr_t cmd_address,
    input logic      cmd_start,
    input logic      cmd_write,
    input logic      cmd_stop,
    input logic      cmd_valid,
    input logic      cmd_ready,
    input i2c_byte_t data_out,
    input logic      data_out_valid,
    input logic      data_out_ready
);

    int fail_count = 0;

    // command beat held until accepted
    cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=>
            cmd_valid && $stable({cmd_address, cmd_start, cmd_write, cmd_stop}))
    else begin
        $error("command beat dropped or changed before cmd_ready");
        fail_count++;
    end

    // data beat, same rule on its own channel
    data_hold: assert property (@(posedge clk) disable iff (rst)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out))
    else begin
        $error("data beat dropped or changed before data_out_ready");
        fail_count++;
    end

    stop_alone: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && cmd_stop |-> !cmd_start && !cmd_write)  // stop is a bare beat
    else begin
        $error("stop beat carries start or write");
        fail_count++;
    end

    // sync reset clears both valids
    quiet_after_rst: assert property (@(posedge clk)
        rst |=> !cmd_valid && !data_out_valid)
    else begin
        $error("valid high in the cycle after reset");
        fail_count++;
    end

endmodule

// ==== bench/tb_i2c_init.sv ====
/*
 * testbench for i2c_init_top, two mux devices at 0x69 then 0x68
 * expected beats come from the 21 register pairs below
 * readys are either held high or taken from a 32-bit LFSR
 */

`timescale 1ns/1ps

module tb_i2c_init import i2c_init_pkg::*; ();

    localparam int NUM_REGS    = 21;
    localparam int STOP_LIMIT  = 6000;  // cycles for one full run under back-pressure
    localparam int IDLE_LIMIT  = 20;
    localparam int HOLD_CYCLES = 40;

    // {register, value} per write, same for both devices
    localparam logic [15:0] REG_TABLE [NUM_REGS] = '{
        16'h02A0, 16'h0310, 16'h05ED, 16'h063D, 16'h073A, 16'h143E, 16'h1940,
        16'h1B05, 16'h1E05, 16'h2105, 16'h2405, 16'h2705, 16'h28A0, 16'h2901,
        16'h2A3B, 16'h2D4E, 16'h304E, 16'h334E, 16'h364E, 16'h8D00, 16'h8840
    };
    localparam i2c_addr_t DEV_ADDRS [2] = '{7'h69, 7'h68}; // service order

    logic      clk = 1'b0;
    logic      rst, start, cmd_ready, data_out_ready;
    i2c_addr_t cmd_address;
    logic      cmd_start, cmd_write, cmd_stop, cmd_valid;
    i2c_byte_t data_out;
    logic      data_out_valid, busy;

    logic [9:0]  cmd_seen[$], cmd_exp[$];   // {addr, start, write, stop}
    i2c_byte_t   data_seen[$], data_exp[$];
    int          val_errs, other_errs, stop_count;
    logic        random_ready;
    logic [31:0] lfsr_state;

    i2c_init_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready),
        .busy           (busy)
    );

    bind i2c_init_top i2c_init_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

    always #4 clk = ~clk;  // 8 ns period

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // readys change on the falling edge only
    always @(negedge clk) begin
        if (random_ready) begin
            lfsr_state = lfsr_next(lfsr_state);
            cmd_ready = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            data_out_ready = lfsr_state[0];
        end else begin
            cmd_ready = 1'b1;
            data_out_ready = 1'b1;
        end
    end

    // record accepted beats
    always @(posedge clk) begin
        if (!rst) begin
            if (cmd_valid && cmd_ready) begin
                cmd_seen.push_back({cmd_address, cmd_start, cmd_write, cmd_stop});
                if (cmd_stop)
                    stop_count++;
                assert (busy || cmd_stop) else begin
                    $display("busy low while a write beat was accepted");
                    other_errs++;
                end
            end
            if (data_out_valid && data_out_ready)
                data_seen.push_back(data_out);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            val_errs++;
        end
    endtask

    // two beats per register write, start only on the first
    task automatic build_expected();
        cmd_exp.delete();
        data_exp.delete();
        for (int d = 0; d < 2; d++) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                cmd_exp.push_back({DEV_ADDRS[d], 3'b110});
                data_exp.push_back(REG_TABLE[i][15:8]);
                cmd_exp.push_back({DEV_ADDRS[d], 3'b010});
                data_exp.push_back(REG_TABLE[i][7:0]);
            end
        end
        cmd_exp.push_back({7'h00, 3'b001}); // stop, address don't care
    endtask

    task automatic compare_streams(input string test);
        check_value({test, " cmd beat count"}, cmd_exp.size(), cmd_seen.size());
        check_value({test, " data beat count"}, data_exp.size(), data_seen.size());
        for (int i = 0; i < cmd_exp.size() && i < cmd_seen.size(); i++) begin
            if (cmd_exp[i][0])
                check_value({test, " stop beat"}, cmd_exp[i][2:0], cmd_seen[i][2:0]);
            else
                check_value($sformatf("%s cmd beat %0d", test, i), cmd_exp[i], cmd_seen[i]);
        end
        for (int i = 0; i < data_exp.size() && i < data_seen.size(); i++)
            check_value($sformatf("%s data beat %0d", test, i), data_exp[i], data_seen[i]);
    endtask

    task automatic check_quiet(input string test, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value({test, " cmd_valid"}, 0, cmd_valid);
            check_value({test, " data_out_valid"}, 0, data_out_valid);
            check_value({test, " busy"}, 0, busy);
        end
        check_value({test, " accepted beats"}, 0, cmd_seen.size() + data_seen.size());
    endtask

    task automatic run_stream(input string test, input logic random);
        int base;
        int n;
        @(posedge clk);
        random_ready = random;  // takes effect at the next falling edge
        @(negedge clk);
        cmd_seen.delete();
        data_seen.delete();
        base = stop_count;
        start = 1'b0;           // one low cycle rearms the edge detect
        @(negedge clk);
        start = 1'b1;
        n = 0;
        while (stop_count == base && n < STOP_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (stop_count != base) else begin
            $display("%s: no stop beat accepted before the timeout", test);
            other_errs++;
        end
        n = 0;
        while (busy && n < IDLE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (!busy) else begin
            $display("%s: busy still high after the stop beat", test);
            other_errs++;
        end
        // start stays high, nothing more may happen
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk);
            check_value({test, " busy during hold"}, 0, busy);
        end
        compare_streams(test);
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        cmd_ready = 1'b1;
        data_out_ready = 1'b1;
        random_ready = 1'b0;
        lfsr_state = 32'hce8c;
        val_errs = 0;
        other_errs = 0;
        stop_count = 0;
        build_expected();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_quiet("idle_after_reset", 20);
        run_stream("full_ready", 1'b0);
        run_stream("lfsr_ready", 1'b1);
        run_stream("restart", 1'b0);   // second edge replays the stream

        $display("value errors %0d, other errors %0d, assertion failures %0d",
                 val_errs, other_errs, i_dut.u_checker.fail_count);
        if (val_errs + other_errs + i_dut.u_checker.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+common
common/i2c_init_pkg.sv
common/seq_cmd_if.sv
sequencer/init_rom.sv
sequencer/i2c_init_sequencer.sv
source/i2c_master_out.sv
source/i2c_init_top.sv
bench/i2c_init_checker.sv
bench/tb_i2c_init.sv
